// ==== gen2_tx_pkg.sv ====
package gen2_tx_pkg;

	// line code of a frame
	typedef enum logic {
		LC_FM0     = 1'b0,
		LC_MILLER2 = 1'b1
	} line_code_e;

	typedef enum logic [1:0] {
		GET_DATA = 2'b00,	// pilot, no data yet
		DATA_P   = 2'b01,	// subcarrier in phase
		DATA_N   = 2'b10	// subcarrier inverted
	} mil_state_e;

	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		PILOT = 3'd1,
		BITS  = 3'd2,
		EOF   = 3'd3,
		DONE  = 3'd4
	} seq_state_e;

	// subcarrier counter end values, without and with trext
	localparam logic [5:0] PILOT_SHORT = 6'd9;
	localparam logic [5:0] PILOT_LONG  = 6'd33;

	localparam int BIT_CYCLES  = 4;	// clk_mil cycles per data bit
	localparam int EOF_STROBES = 3;
	localparam int MAX_BITS    = 32;
	localparam int LEN_W       = 6;	// frame length field, 1 to 32

endpackage

// ==== gen2_regs_pkg.sv ====
package gen2_regs_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	// register offsets
	localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h0;
	localparam logic [ADDR_W-1:0] REG_DATA   = 4'h4;
	localparam logic [ADDR_W-1:0] REG_LEN    = 4'h8;
	localparam logic [ADDR_W-1:0] REG_STATUS = 4'hC;	// read only

	// CTRL fields
	localparam int CTRL_START = 0;	// self clearing
	localparam int CTRL_LCODE = 1;
	localparam int CTRL_TREXT = 2;

	// STATUS fields
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== tx_axil_regs.sv ====
`timescale 1ns/10ps
module tx_axil_regs (
	input  logic clk_mil,
	input  logic rst_for_new_package,
	input  logic [gen2_regs_pkg::ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [gen2_regs_pkg::DATA_W-1:0] wdata,
	input  logic [gen2_regs_pkg::DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input  logic bready,
	input  logic [gen2_regs_pkg::ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [gen2_regs_pkg::DATA_W-1:0] rdata,
	output logic rvalid,
	output logic [1:0] rresp,
	input  logic rready,
	input  logic busy,
	input  logic done_pulse,
	output logic go,
	output gen2_tx_pkg::line_code_e line_code,
	output logic trext,
	output logic [gen2_tx_pkg::MAX_BITS-1:0] frame_bits,
	output logic [gen2_tx_pkg::LEN_W-1:0] frame_len
);

	logic wr_en;
	logic rd_en;
	logic ctrl_sel;
	logic ctrl_wr;
	logic start_req;
	logic done_q;
	logic [gen2_tx_pkg::LEN_W-1:0] len_wr;
	logic [gen2_regs_pkg::DATA_W-1:0] rd_mux;

	assign wr_en   = awvalid && wvalid && !bvalid;	// one response outstanding
	assign awready = wr_en;
	assign wready  = wr_en;
	assign bresp   = gen2_regs_pkg::RESP_OKAY;
	assign arready = !rvalid;
	assign rd_en   = arvalid && !rvalid;
	assign rresp   = gen2_regs_pkg::RESP_OKAY;

	assign ctrl_sel  = wr_en && (awaddr == gen2_regs_pkg::REG_CTRL);
	assign ctrl_wr   = ctrl_sel && wstrb[0];
	assign start_req = ctrl_wr && wdata[gen2_regs_pkg::CTRL_START] && !busy && !go;

	// clamp length into 1..MAX_BITS
	always_comb begin
		len_wr = wdata[gen2_tx_pkg::LEN_W-1:0];
		if (len_wr == '0)
			len_wr = gen2_tx_pkg::LEN_W'(1);
		else if (len_wr > gen2_tx_pkg::LEN_W'(gen2_tx_pkg::MAX_BITS))
			len_wr = gen2_tx_pkg::LEN_W'(gen2_tx_pkg::MAX_BITS);
	end

	always_ff @(posedge clk_mil or negedge rst_for_new_package) begin
		if (!rst_for_new_package) begin
			bvalid     <= 1'b0;
			rvalid     <= 1'b0;
			go         <= 1'b0;
			line_code  <= gen2_tx_pkg::LC_FM0;
			trext      <= 1'b0;
			frame_bits <= '0;
			frame_len  <= gen2_tx_pkg::LEN_W'(1);
			done_q     <= 1'b0;
		end else begin
			go <= start_req;
			if (wr_en)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_en)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (ctrl_wr && !busy) begin	// frame config frozen while sending
				line_code <= gen2_tx_pkg::line_code_e'(wdata[gen2_regs_pkg::CTRL_LCODE]);
				trext     <= wdata[gen2_regs_pkg::CTRL_TREXT];
			end
			if (wr_en && awaddr == gen2_regs_pkg::REG_DATA) begin
				for (int i = 0; i < gen2_regs_pkg::DATA_W / 8; i++) begin
					if (wstrb[i])
						frame_bits[8*i +: 8] <= wdata[8*i +: 8];
				end
			end
			if (wr_en && awaddr == gen2_regs_pkg::REG_LEN && wstrb[0])
				frame_len <= len_wr;
			if (done_pulse)
				done_q <= 1'b1;
			else if (ctrl_sel)
				done_q <= 1'b0;	// sticky until next CTRL write
		end
	end

	always_comb begin
		rd_mux = '0;
		case (araddr)
			gen2_regs_pkg::REG_CTRL: begin
				rd_mux[gen2_regs_pkg::CTRL_LCODE] = line_code;
				rd_mux[gen2_regs_pkg::CTRL_TREXT] = trext;
			end
			gen2_regs_pkg::REG_DATA:   rd_mux = frame_bits;
			gen2_regs_pkg::REG_LEN:    rd_mux[gen2_tx_pkg::LEN_W-1:0] = frame_len;
			gen2_regs_pkg::REG_STATUS: begin
				rd_mux[gen2_regs_pkg::STAT_BUSY] = busy;
				rd_mux[gen2_regs_pkg::STAT_DONE] = done_q;
			end
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_mil) begin
		if (rd_en)
			rdata <= rd_mux;
	end

	// start is only honoured between frames
	a_no_go_busy: assert property (@(posedge clk_mil) disable iff (!rst_for_new_package)
		busy |-> !go);

endmodule

// ==== tx_frame_ctrl.sv ====
`timescale 1ns/10ps
module tx_frame_ctrl (
	input  logic clk_mil,
	input  logic rst_for_new_package,
	input  logic go,
	input  gen2_tx_pkg::line_code_e line_code,
	input  logic trext,
	input  logic [gen2_tx_pkg::MAX_BITS-1:0] frame_bits,
	input  logic [gen2_tx_pkg::LEN_W-1:0] frame_len,
	input  logic mil_complete,
	output logic busy,
	output logic done_pulse,
	output logic clk_blf,
	output logic st_enc,
	output logic en_fm0,
	output logic send_data,
	output logic fg_complete,
	output logic bit_val
);

	gen2_tx_pkg::seq_state_e state;
	gen2_tx_pkg::seq_state_e state_nx;
	gen2_tx_pkg::line_code_e lc_q;
	logic [5:0] cnt;	// pilot, bit or eof cycle
	logic [gen2_tx_pkg::LEN_W-1:0] bit_idx;
	logic [gen2_tx_pkg::LEN_W-1:0] len_q;
	logic [gen2_tx_pkg::MAX_BITS-1:0] sh_q;	// msb is the current bit
	logic prev_bit;
	logic blf_q;
	logic [5:0] pilot_end;
	logic cur_bit;
	logic bit_last;
	logic eof_end;

	assign pilot_end = trext ? gen2_tx_pkg::PILOT_LONG : gen2_tx_pkg::PILOT_SHORT;
	assign cur_bit   = sh_q[gen2_tx_pkg::MAX_BITS-1];
	assign bit_last  = (cnt == 6'(gen2_tx_pkg::BIT_CYCLES - 1));
	assign eof_end   = (lc_q == gen2_tx_pkg::LC_MILLER2) ? mil_complete :
		(cnt == 6'(gen2_tx_pkg::EOF_STROBES));

	always_comb begin
		state_nx = state;
		case (state)
			gen2_tx_pkg::IDLE:
				if (go)
					state_nx = (line_code == gen2_tx_pkg::LC_FM0) ? gen2_tx_pkg::BITS :
						gen2_tx_pkg::PILOT;
			gen2_tx_pkg::PILOT:
				if (cnt == pilot_end - 6'd1)
					state_nx = gen2_tx_pkg::BITS;
			gen2_tx_pkg::BITS:
				if (bit_last && bit_idx == len_q - 1'b1)
					state_nx = gen2_tx_pkg::EOF;
			gen2_tx_pkg::EOF:
				if (eof_end)
					state_nx = gen2_tx_pkg::DONE;
			default: state_nx = gen2_tx_pkg::IDLE;	// DONE lasts one cycle
		endcase
	end

	always_ff @(posedge clk_mil or negedge rst_for_new_package) begin
		if (!rst_for_new_package) begin
			state    <= gen2_tx_pkg::IDLE;
			lc_q     <= gen2_tx_pkg::LC_FM0;
			cnt      <= '0;
			bit_idx  <= '0;
			prev_bit <= 1'b1;
			blf_q    <= 1'b0;
		end else begin
			state <= state_nx;
			blf_q <= busy ? ~blf_q : 1'b0;
			case (state)
				gen2_tx_pkg::IDLE: begin
					cnt      <= '0;
					bit_idx  <= '0;
					prev_bit <= 1'b1;	// no boundary flip before the first bit
					if (go)
						lc_q <= line_code;
				end
				gen2_tx_pkg::PILOT:
					cnt <= (state_nx == gen2_tx_pkg::BITS) ? 6'd0 : cnt + 6'd1;
				gen2_tx_pkg::BITS: begin
					if (bit_last) begin
						cnt      <= '0;
						bit_idx  <= bit_idx + 1'b1;
						prev_bit <= cur_bit;
					end else begin
						cnt <= cnt + 6'd1;
					end
				end
				gen2_tx_pkg::EOF: cnt <= cnt + 6'd1;
				default: cnt <= '0;
			endcase
		end
	end

	always_ff @(posedge clk_mil) begin
		if (state == gen2_tx_pkg::IDLE && go) begin
			sh_q  <= frame_bits << (gen2_tx_pkg::MAX_BITS - frame_len);	// left align
			len_q <= frame_len;
		end else if (state == gen2_tx_pkg::BITS && bit_last) begin
			sh_q <= sh_q << 1;
		end
	end

	assign busy        = (state == gen2_tx_pkg::PILOT) || (state == gen2_tx_pkg::BITS) ||
		(state == gen2_tx_pkg::EOF);
	assign st_enc      = busy;
	assign done_pulse  = (state == gen2_tx_pkg::DONE);
	assign clk_blf     = busy & blf_q;
	assign en_fm0      = (lc_q == gen2_tx_pkg::LC_FM0);
	assign bit_val     = (state == gen2_tx_pkg::BITS) ? cur_bit : 1'b1;	// dummy 1 in eof
	assign fg_complete = (state == gen2_tx_pkg::EOF) && (cnt < 6'(gen2_tx_pkg::EOF_STROBES));

	// Miller rule: mid-bit flip for a 1, boundary flip between two 0s
	assign send_data = (state == gen2_tx_pkg::BITS) && !en_fm0 &&
		((cnt == 6'(gen2_tx_pkg::BIT_CYCLES / 2) && cur_bit) ||
		(cnt == 6'd0 && !cur_bit && !prev_bit));

	a_idle_quiet: assert property (@(posedge clk_mil) disable iff (!rst_for_new_package)
		(state == gen2_tx_pkg::IDLE) |-> !send_data && !fg_complete);

	a_bit_idx: assert property (@(posedge clk_mil) disable iff (!rst_for_new_package)
		(state == gen2_tx_pkg::BITS) |-> (bit_idx < len_q));

endmodule

// ==== miller_enc.sv ====
`timescale 1ns/10ps
module miller_enc (
	output logic miller_data,
	output logic mil_complete,
	input  logic clk_mil,
	input  logic rst_for_new_package,
	input  logic clk_blf,
	input  logic send_data,
	input  logic en_fm0,
	input  logic trext,
	input  logic st_enc,
	input  logic fg_complete
);

	gen2_tx_pkg::mil_state_e ps;
	gen2_tx_pkg::mil_state_e ns;
	logic [5:0] mp_end;
	logic [5:0] mp_cnt;	// pilot subcarrier half periods
	logic m_cnt;	// flip allowed on odd halves
	logic [1:0] fg_cnt;
	logic mp_complete;
	logic me_start;
	logic m1o;

	assign mp_end      = trext ? gen2_tx_pkg::PILOT_LONG : gen2_tx_pkg::PILOT_SHORT;
	assign mp_complete = (mp_cnt == mp_end);
	assign me_start    = (mp_cnt > mp_end - 6'd2);
	assign mil_complete = (fg_cnt == 2'(gen2_tx_pkg::EOF_STROBES));

	always_ff @(posedge clk_mil or negedge rst_for_new_package) begin
		if (!rst_for_new_package) begin
			mp_cnt <= '0;
			m_cnt  <= 1'b0;
			fg_cnt <= '0;
		end else if (!st_enc) begin	// cleared between frames
			mp_cnt <= '0;
			m_cnt  <= 1'b0;
			fg_cnt <= '0;
		end else begin
			if (!mp_complete && !en_fm0)
				mp_cnt <= mp_cnt + 6'd1;
			if (me_start)
				m_cnt <= ~m_cnt;
			if (!mil_complete && !en_fm0 && fg_complete)
				fg_cnt <= fg_cnt + 2'd1;
		end
	end

	always_ff @(posedge clk_mil or negedge rst_for_new_package) begin
		if (!rst_for_new_package)
			ps <= gen2_tx_pkg::GET_DATA;
		else if (st_enc)
			ps <= ns;
	end

	always_comb begin
		ns = ps;
		case (ps)
			gen2_tx_pkg::GET_DATA:
				if (!en_fm0 && me_start)
					ns = gen2_tx_pkg::DATA_P;
			gen2_tx_pkg::DATA_P:
				if (mil_complete)
					ns = gen2_tx_pkg::GET_DATA;
				else if (send_data && m_cnt)
					ns = gen2_tx_pkg::DATA_N;
			gen2_tx_pkg::DATA_N:
				if (mil_complete)
					ns = gen2_tx_pkg::GET_DATA;
				else if (send_data && m_cnt)
					ns = gen2_tx_pkg::DATA_P;
			default: ns = gen2_tx_pkg::GET_DATA;
		endcase
	end

	always_comb begin
		case (ps)
			gen2_tx_pkg::DATA_P: m1o = clk_blf;
			gen2_tx_pkg::DATA_N: m1o = ~clk_blf;
			default:             m1o = 1'b0;
		endcase
	end

	// plain subcarrier during pilot, blank once the frame is complete
	assign miller_data = (mp_cnt != 6'd0 && !mil_complete) ? (mp_complete ? m1o : clk_blf) :
		1'b0;

	a_state_legal: assert property (@(posedge clk_mil) disable iff (!rst_for_new_package)
		ps inside {gen2_tx_pkg::GET_DATA, gen2_tx_pkg::DATA_P, gen2_tx_pkg::DATA_N});

	// held until the sequencer drops st_enc for the next frame
	a_complete_hold: assert property (@(posedge clk_mil) disable iff (!rst_for_new_package)
		mil_complete && st_enc |=> mil_complete);

endmodule

// ==== line_code_out.sv ====
`timescale 1ns/10ps
module line_code_out (
	input  logic clk_mil,
	input  logic rst_for_new_package,
	input  logic en_fm0,
	input  logic st_enc,
	input  logic clk_blf,
	input  logic bit_val,
	input  logic miller_data,
	output logic bs_out
);

	logic half_hi;	// second half of the bit
	logic last_lvl;	// level at the end of the previous bit
	logic fm0_now;

	// boundary always flips, a 0 flips again at mid-bit
	assign fm0_now = ~last_lvl ^ (half_hi & ~bit_val);

	always_ff @(posedge clk_mil or negedge rst_for_new_package) begin
		if (!rst_for_new_package) begin
			half_hi  <= 1'b0;
			last_lvl <= 1'b0;
		end else if (!st_enc) begin
			half_hi  <= 1'b0;
			last_lvl <= 1'b0;	// idle line is low
		end else begin
			if (clk_blf)
				half_hi <= ~half_hi;	// one blf period per half bit
			if (en_fm0 && half_hi && clk_blf)
				last_lvl <= fm0_now;	// bit boundary
		end
	end

	assign bs_out = !st_enc ? 1'b0 : (en_fm0 ? fm0_now : miller_data);

endmodule

// ==== gen2_tx_top.sv ====
`timescale 1ns/10ps
module gen2_tx_top (
	input  logic clk_mil,
	input  logic rst_for_new_package,
	input  logic [gen2_regs_pkg::ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [gen2_regs_pkg::DATA_W-1:0] wdata,
	input  logic [gen2_regs_pkg::DATA_W/8-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input  logic bready,
	input  logic [gen2_regs_pkg::ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [gen2_regs_pkg::DATA_W-1:0] rdata,
	output logic rvalid,
	output logic [1:0] rresp,
	input  logic rready,
	output logic bs_out
);

	logic go;
	gen2_tx_pkg::line_code_e line_code;
	logic trext;
	logic [gen2_tx_pkg::MAX_BITS-1:0] frame_bits;
	logic [gen2_tx_pkg::LEN_W-1:0] frame_len;
	logic busy;
	logic done_pulse;
	logic clk_blf;
	logic st_enc;
	logic en_fm0;
	logic send_data;
	logic fg_complete;
	logic bit_val;
	logic miller_data;
	logic mil_complete;

	tx_axil_regs regs0 (
		.clk_mil(clk_mil), .rst_for_new_package(rst_for_new_package),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rresp(rresp), .rready(rready),
		.busy(busy), .done_pulse(done_pulse), .go(go), .line_code(line_code),
		.trext(trext), .frame_bits(frame_bits), .frame_len(frame_len)
	);

	tx_frame_ctrl seq0 (
		.clk_mil(clk_mil), .rst_for_new_package(rst_for_new_package),
		.go(go), .line_code(line_code), .trext(trext), .frame_bits(frame_bits),
		.frame_len(frame_len), .mil_complete(mil_complete), .busy(busy),
		.done_pulse(done_pulse), .clk_blf(clk_blf), .st_enc(st_enc), .en_fm0(en_fm0),
		.send_data(send_data), .fg_complete(fg_complete), .bit_val(bit_val)
	);

	miller_enc mil0 (
		.miller_data(miller_data), .mil_complete(mil_complete),
		.clk_mil(clk_mil), .rst_for_new_package(rst_for_new_package),
		.clk_blf(clk_blf), .send_data(send_data), .en_fm0(en_fm0), .trext(trext),
		.st_enc(st_enc), .fg_complete(fg_complete)
	);

	line_code_out out0 (
		.clk_mil(clk_mil), .rst_for_new_package(rst_for_new_package),
		.en_fm0(en_fm0), .st_enc(st_enc), .clk_blf(clk_blf), .bit_val(bit_val),
		.miller_data(miller_data), .bs_out(bs_out)
	);

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps
module tb_checker (
	input  logic clk_mil,
	input  logic rst_for_new_package,
	input  logic st_enc,
	input  logic bs_out,
	input  logic [31:0] cfg_bits,
	input  logic [5:0] cfg_len,
	input  gen2_tx_pkg::line_code_e cfg_lc,
	input  logic cfg_trext
);

	int errors = 0;
	int checks = 0;
	int frames = 0;
	int t;
	int total;
	logic in_frame = 1'b0;
	logic frame_bad;
	logic wave [0:255];	// expected bs_out per cycle of st_enc

	function automatic logic bit_at(input int k);
		return cfg_bits[int'(cfg_len) - 1 - k];	// msb first
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic build_wave();
		int b_start;
		int e_start;
		int k;
		int c;
		logic p;
		logic b;
		logic pb;
		logic lvl;
		logic l_end;
		if (cfg_lc == gen2_tx_pkg::LC_MILLER2) begin
			b_start = cfg_trext ? int'(gen2_tx_pkg::PILOT_LONG) : int'(gen2_tx_pkg::PILOT_SHORT);
			e_start = b_start + int'(cfg_len) * gen2_tx_pkg::BIT_CYCLES;
			total = e_start + gen2_tx_pkg::EOF_STROBES + 1;	// blank cycle after 3rd strobe
			p = 1'b0;
			for (int i = 0; i < total; i++) begin
				if (i == 0)
					wave[i] = 1'b0;
				else if (i < b_start)
					wave[i] = 1'(i % 2);	// pilot subcarrier
				else if (i < e_start + gen2_tx_pkg::EOF_STROBES) begin
					if (i < e_start) begin
						k = (i - b_start) / gen2_tx_pkg::BIT_CYCLES;
						c = (i - b_start) % gen2_tx_pkg::BIT_CYCLES;
						b = bit_at(k);
						pb = (k > 0) ? bit_at(k - 1) : 1'b1;
						// flips land one half period after the request
						if (c == 3 && b)
							p = ~p;
						if (c == 1 && !b && !pb)
							p = ~p;
					end
					wave[i] = 1'(i % 2) ^ p;
				end else
					wave[i] = 1'b0;
			end
		end else begin
			total = (int'(cfg_len) + 1) * gen2_tx_pkg::BIT_CYCLES;	// eof acts as a dummy 1
			l_end = 1'b0;
			for (int i = 0; i < total; i++) begin
				k = i / gen2_tx_pkg::BIT_CYCLES;
				c = i % gen2_tx_pkg::BIT_CYCLES;
				b = (k < int'(cfg_len)) ? bit_at(k) : 1'b1;
				lvl = (c < 2) ? ~l_end : (~l_end ^ ~b);
				wave[i] = lvl;
				if (c == 3)
					l_end = lvl;
			end
		end
	endtask

	always @(posedge clk_mil) begin
		if (!rst_for_new_package) begin
			in_frame = 1'b0;
		end else if (st_enc) begin
			if (!in_frame) begin
				in_frame = 1'b1;
				frame_bad = 1'b0;
				t = 0;
				build_wave();
			end
			if (t < total && bs_out !== wave[t] && !frame_bad) begin
				frame_bad = 1'b1;	// first bad cycle only
				check_value($sformatf("frame %0d cycle %0d", frames, t), 32'(wave[t]), 32'(bs_out));
			end
			t++;
		end else if (in_frame) begin
			in_frame = 1'b0;
			check_value($sformatf("frame %0d length", frames), 32'(total), 32'(t));
			if (!frame_bad)
				checks++;
			$display("frame %0d: %s len %0d trext %0b, %0d cycles, %s", frames, cfg_lc.name(),
				cfg_len, cfg_trext, t, (frame_bad || t != total) ? "wrong" : "ok");
			frames++;
		end else if (bs_out !== 1'b0) begin
			check_value("idle line", 32'd0, 32'(bs_out));
		end
	end

endmodule

// ==== tb_gen2_tx.sv ====
`timescale 1ns/10ps
module tb_gen2_tx;

	localparam int TIMEOUT = 50;
	localparam int DONE_POLLS = 100;	// longest frame needs about 55 polls

	logic clk_mil = 1'b0;
	logic rst_for_new_package;
	logic [3:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic bready;
	logic [3:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic rvalid;
	logic [1:0] rresp;
	logic rready;
	logic bs_out;
	logic [31:0] rng = 32'h4161c39b;
	int stall_max = 0;
	int tests = 0;
	int frames_exp = 0;
	logic [31:0] cfg_bits = '0;
	logic [5:0] cfg_len = 6'd1;
	gen2_tx_pkg::line_code_e cfg_lc = gen2_tx_pkg::LC_FM0;
	logic cfg_trext = 1'b0;

	always #50 clk_mil = ~clk_mil;

	gen2_tx_top dut0 (
		.clk_mil(clk_mil), .rst_for_new_package(rst_for_new_package),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rresp(rresp), .rready(rready),
		.bs_out(bs_out)
	);

	tb_checker chk0 (
		.clk_mil(clk_mil), .rst_for_new_package(rst_for_new_package),
		.st_enc(dut0.st_enc), .bs_out(bs_out), .cfg_bits(cfg_bits),
		.cfg_len(cfg_len), .cfg_lc(cfg_lc), .cfg_trext(cfg_trext)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic stall_cycles();
		int n;
		n = 0;
		if (stall_max > 0) begin
			rng = xorshift(rng);
			n = int'(rng % 32'(stall_max + 1));
		end
		repeat (n) begin
			@(posedge clk_mil);
			#10;
		end
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] strb);
		int cnt;
		@(posedge clk_mil);
		#10;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		cnt = 0;
		@(negedge clk_mil);
		while (!(awready && wready)) begin
			cnt++;
			if (cnt > TIMEOUT)
				give_up("write address and data acceptance");
			@(negedge clk_mil);
		end
		@(posedge clk_mil);
		#10;
		awvalid = 1'b0;
		wvalid = 1'b0;
		stall_cycles();	// bready held low
		bready = 1'b1;
		cnt = 0;
		@(negedge clk_mil);
		while (!bvalid) begin
			cnt++;
			if (cnt > TIMEOUT)
				give_up("write response");
			@(negedge clk_mil);
		end
		chk0.check_value("write response", 32'h0, 32'(bresp));	// okay only
		@(posedge clk_mil);
		#10;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		int cnt;
		@(posedge clk_mil);
		#10;
		araddr = addr;
		arvalid = 1'b1;
		cnt = 0;
		@(negedge clk_mil);
		while (!arready) begin
			cnt++;
			if (cnt > TIMEOUT)
				give_up("read address acceptance");
			@(negedge clk_mil);
		end
		@(posedge clk_mil);
		#10;
		arvalid = 1'b0;
		stall_cycles();
		rready = 1'b1;
		cnt = 0;
		@(negedge clk_mil);
		while (!rvalid) begin
			cnt++;
			if (cnt > TIMEOUT)
				give_up("read data");
			@(negedge clk_mil);
		end
		data = rdata;
		chk0.check_value("read response", 32'h0, 32'(rresp));
		@(posedge clk_mil);
		#10;
		rready = 1'b0;
	endtask

	task automatic end_test(input string name, input int base);
		tests++;
		$display("test %s finished, %0d errors", name, chk0.errors - base);
	endtask

	task automatic run_frame(input logic lc, input logic tx, input logic [31:0] bits,
		input logic [5:0] len, input logic see_busy, input logic poke);
		logic [31:0] rd;
		int cnt;
		cfg_bits = bits;
		cfg_len = len;
		cfg_lc = gen2_tx_pkg::line_code_e'(lc);
		cfg_trext = tx;
		axi_write(gen2_regs_pkg::REG_DATA, bits, 4'hf);
		axi_write(gen2_regs_pkg::REG_LEN, 32'(len), 4'hf);
		axi_write(gen2_regs_pkg::REG_CTRL, {29'd0, tx, lc, 1'b1}, 4'hf);
		frames_exp++;
		if (poke) begin
			axi_write(gen2_regs_pkg::REG_CTRL, {29'd0, ~tx, ~lc, 1'b1}, 4'hf);
			axi_read(gen2_regs_pkg::REG_CTRL, rd);
			chk0.check_value("ctrl frozen while busy", {29'd0, tx, lc, 1'b0}, rd);
		end
		if (see_busy) begin
			axi_read(gen2_regs_pkg::REG_STATUS, rd);
			chk0.check_value("status busy", 32'h1, rd);
		end
		cnt = 0;
		axi_read(gen2_regs_pkg::REG_STATUS, rd);
		while (!rd[gen2_regs_pkg::STAT_DONE]) begin
			cnt++;
			if (cnt > DONE_POLLS)
				give_up("status done");
			axi_read(gen2_regs_pkg::REG_STATUS, rd);
		end
		chk0.check_value("status done", 32'h2, rd);
		chk0.check_value("frame count", 32'(frames_exp), 32'(chk0.frames));
	endtask

	initial begin
		int base;
		logic [31:0] rd;
		logic [5:0] len;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		rst_for_new_package = 1'b0;
		repeat (8) @(posedge clk_mil);
		#10;
		rst_for_new_package = 1'b1;

		base = chk0.errors;
		axi_read(gen2_regs_pkg::REG_STATUS, rd);
		chk0.check_value("status after reset", 32'h0, rd);
		axi_write(gen2_regs_pkg::REG_DATA, 32'ha5a51234, 4'hf);
		axi_read(gen2_regs_pkg::REG_DATA, rd);
		chk0.check_value("data full write", 32'ha5a51234, rd);
		axi_write(gen2_regs_pkg::REG_DATA, 32'hffffffff, 4'b0010);
		axi_read(gen2_regs_pkg::REG_DATA, rd);
		chk0.check_value("data byte 1 write", 32'ha5a5ff34, rd);
		axi_write(gen2_regs_pkg::REG_LEN, 32'd17, 4'hf);
		axi_read(gen2_regs_pkg::REG_LEN, rd);
		chk0.check_value("len write", 32'd17, rd);
		axi_write(gen2_regs_pkg::REG_LEN, 32'd5, 4'b1110);
		axi_read(gen2_regs_pkg::REG_LEN, rd);
		chk0.check_value("len masked write", 32'd17, rd);
		axi_write(gen2_regs_pkg::REG_CTRL, 32'h6, 4'hf);
		axi_read(gen2_regs_pkg::REG_CTRL, rd);
		chk0.check_value("ctrl write", 32'h6, rd);
		axi_write(gen2_regs_pkg::REG_CTRL, 32'h0, 4'b1110);
		axi_read(gen2_regs_pkg::REG_CTRL, rd);
		chk0.check_value("ctrl masked write", 32'h6, rd);
		end_test("registers", base);

		base = chk0.errors;
		rng = xorshift(rng);
		len = 6'(rng[4:0]) + 6'd1;
		rng = xorshift(rng);
		run_frame(1'b1, 1'b0, rng, len, 1'b1, 1'b0);
		end_test("miller", base);

		base = chk0.errors;
		rng = xorshift(rng);
		len = 6'(rng[4:0]) + 6'd1;
		rng = xorshift(rng);
		run_frame(1'b1, 1'b1, rng, len, 1'b1, 1'b0);
		end_test("miller trext", base);

		base = chk0.errors;
		rng = xorshift(rng);
		len = 6'(rng[4:0]) + 6'd1;
		rng = xorshift(rng);
		run_frame(1'b0, 1'b0, rng, len, 1'b1, 1'b0);
		end_test("fm0", base);

		base = chk0.errors;
		rng = xorshift(rng);
		run_frame(1'b1, 1'b0, rng, 6'd32, 1'b0, 1'b1);
		repeat (10) @(posedge clk_mil);
		chk0.check_value("no extra frame", 32'(frames_exp), 32'(chk0.frames));
		end_test("start while busy", base);

		base = chk0.errors;
		stall_max = 4;
		for (int i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			len = 6'(rng[4:0]) + 6'd1;
			rng = xorshift(rng);
			run_frame(rng[31], rng[30], xorshift(rng), len, 1'b0, 1'b0);
		end
		end_test("back to back", base);

		$display("tests %0d, checks %0d, frames %0d, errors %0d", tests, chk0.checks,
			chk0.frames, chk0.errors);
		if (chk0.errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
gen2_tx_pkg.sv
gen2_regs_pkg.sv
tx_axil_regs.sv
tx_frame_ctrl.sv
miller_enc.sv
line_code_out.sv
gen2_tx_top.sv
tb_checker.sv
tb_gen2_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gen2_tx -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb_gen2_tx)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
	exit 0
fi
echo "pass message not found"
exit 1
